// File: common/if_pkg.sv
package if_pkg;

   // memory geometry.
   localparam int ADDR_BITS  = 11;
   localparam int INSTR_BITS = 32;
   localparam int MEM_DEPTH  = 2048;

   typedef logic [ADDR_BITS-1:0]  addr_t;   // pc values and memory addresses.
   typedef logic [INSTR_BITS-1:0] instr_t;  // instruction words.

   // and r1, r1, r1 stands in for a nop.
   localparam instr_t NOP_INSTR = 32'h0021_0824;
   localparam instr_t IR_RESET  = '1;
   localparam addr_t  PC_RESET  = '0;

   // one program memory write from the loader.
   typedef struct packed {
      logic   we;
      addr_t  addr;
      instr_t data;
   } mem_wr_t;

   // bundle handed to decode.
   typedef struct packed {
      instr_t instr;
      addr_t  pc;
      addr_t  pc_next;
   } fetch_out_t;

   typedef enum logic [0:0] {
      LD_IDLE,
      LD_LOAD
   } loader_state_t;

endpackage

// File: rtl/prog_loader.sv
`timescale 1ns/1ns

module prog_loader (
   input  logic              i_clock,
   input  logic              i_soft_reset,
   input  logic              i_load_start,
   input  logic              i_load_done,
   input  logic              i_load_valid,
   input  if_pkg::instr_t    i_load_word,
   output if_pkg::mem_wr_t   o_wr,
   output logic              o_loading
);

   if_pkg::loader_state_t state;
   if_pkg::loader_state_t state_next;
   if_pkg::addr_t         wr_addr;
   logic                  wr_en;

   always_comb begin
      state_next = state;
      case (state)
         if_pkg::LD_IDLE: begin
            if (i_load_start) state_next = if_pkg::LD_LOAD;
         end
         if_pkg::LD_LOAD: begin
            if (i_load_done) state_next = if_pkg::LD_IDLE;
         end
         default: state_next = if_pkg::LD_IDLE;
      endcase
   end

   // strobes outside a load are dropped.
   assign wr_en = i_load_valid && (state == if_pkg::LD_LOAD);

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state   <= if_pkg::LD_IDLE;
         wr_addr <= '0;
      end else begin
         state <= state_next;
         if (i_load_start) begin
            wr_addr <= '0;               // every load begins at word 0.
         end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;   // wraps past the last word.
         end
      end
   end

   assign o_wr      = '{we: wr_en, addr: wr_addr, data: i_load_word};
   assign o_loading = (state == if_pkg::LD_LOAD);

   // every word written into program memory is a known value.
   a_wr_data_known: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_wr.we |-> !$isunknown(o_wr.data));

   a_start_done_excl: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !(i_load_start && i_load_done));

endmodule

// File: if_stage/prog_mem.sv
`timescale 1ns/1ns

module prog_mem (
   input  logic            i_clock,
   input  logic            i_soft_reset,
   input  if_pkg::addr_t   i_addr,
   input  logic            i_we,
   input  if_pkg::instr_t  i_data,
   output if_pkg::instr_t  o_data
);

   if_pkg::instr_t mem [if_pkg::MEM_DEPTH];
   if_pkg::instr_t rd_data;

   // a write takes the single port for the cycle.
   always_ff @(posedge i_clock) begin
      if (i_we) begin
         mem[i_addr] <= i_data;
      end
   end

   // registered read.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         rd_data <= if_pkg::IR_RESET;
      end else if (!i_we) begin
         rd_data <= mem[i_addr];
      end
   end

   assign o_data = rd_data;

endmodule

// File: if_stage/pc_unit.sv
`timescale 1ns/1ns

module pc_unit (
   input  logic           i_clock,
   input  logic           i_soft_reset,
   input  logic           i_enable,
   input  logic           i_branch,
   input  if_pkg::addr_t  i_branch_addr,
   output if_pkg::addr_t  o_pc,
   output logic           o_flush
);

   if_pkg::addr_t pc;
   if_pkg::addr_t pc_inc;
   logic          flush;

   assign pc_inc = pc + 1'b1;

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         pc    <= if_pkg::PC_RESET;
         flush <= 1'b0;
      end else if (i_enable) begin
         pc    <= i_branch ? i_branch_addr : pc_inc;  // taken branch wins.
         flush <= i_branch;                           // kills the word in flight.
      end
   end

   assign o_pc    = pc;
   assign o_flush = flush;

   // a taken branch is a single-cycle strobe from a later stage.
   a_branch_strobe: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_branch |=> !i_branch);

   a_branch_addr_known: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_enable && i_branch) |-> !$isunknown(i_branch_addr));

endmodule

// File: if_stage/if_stage.sv
`timescale 1ns/1ns

module if_stage (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_enable,
   input  logic                i_branch,
   input  if_pkg::addr_t       i_branch_addr,
   input  if_pkg::mem_wr_t     i_wr,
   input  logic                i_loading,
   output if_pkg::fetch_out_t  o_fetch
);

   if_pkg::addr_t  pc;
   if_pkg::addr_t  pc_next;
   if_pkg::addr_t  mem_addr;
   if_pkg::instr_t mem_word;
   if_pkg::instr_t ir;
   logic           flush;
   logic           pc_en;

   // the loader owns the memory during a load.
   assign pc_en    = i_enable && !i_loading;
   assign mem_addr = i_loading ? i_wr.addr : pc;

   pc_unit u_pc (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (pc_en),
      .i_branch      (i_branch),
      .i_branch_addr (i_branch_addr),
      .o_pc          (pc),
      .o_flush       (flush)
   );

   prog_mem u_mem (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_addr       (mem_addr),
      .i_we         (i_wr.we),
      .i_data       (i_wr.data),
      .o_data       (mem_word)
   );

   // instruction register runs on the falling edge,
   // half a cycle after the memory read.
   always_ff @(negedge i_clock) begin
      if (!i_soft_reset) begin
         ir      <= if_pkg::IR_RESET;
         pc_next <= if_pkg::PC_RESET + 1'b1;
      end else if (!i_loading) begin
         ir      <= flush ? if_pkg::NOP_INSTR : mem_word;  // squash the wrong-path word.
         pc_next <= pc + 1'b1;
      end
   end

   assign o_fetch = '{instr: ir, pc: pc, pc_next: pc_next};

   // pc must not move while the loader has the memory.
   a_pc_held_loading: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      i_loading |=> $stable(pc));

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
   input  logic                i_clock,
   input  logic                i_soft_reset,
   input  logic                i_load_start,
   input  logic                i_load_valid,
   input  if_pkg::instr_t      i_load_word,
   input  logic                i_load_done,
   input  logic                i_enable,
   input  logic                i_branch,
   input  if_pkg::addr_t       i_branch_addr,
   output if_pkg::fetch_out_t  o_fetch,
   output logic                o_loading
);

   if_pkg::mem_wr_t wr;  // loader write into program memory.

   prog_loader u_loader (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_load_start (i_load_start),
      .i_load_done  (i_load_done),
      .i_load_valid (i_load_valid),
      .i_load_word  (i_load_word),
      .o_wr         (wr),
      .o_loading    (o_loading)
   );

   // loading level also freezes fetch.
   if_stage u_if (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (i_enable),
      .i_branch      (i_branch),
      .i_branch_addr (i_branch_addr),
      .i_wr          (wr),
      .i_loading     (o_loading),
      .o_fetch       (o_fetch)
   );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic o_clock,
   output logic o_soft_reset
);

   localparam int HALF_PERIOD  = 50;  // 100 ns period.
   localparam int RESET_CYCLES = 8;

   initial begin
      o_clock = 1'b0;
      forever #HALF_PERIOD o_clock = ~o_clock;
   end

   // reset held low for the first cycles and released on a falling edge.
   initial begin
      o_soft_reset = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clock);
      @(negedge o_clock);
      o_soft_reset <= 1'b1;
   end

endmodule

// File: tests/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;

   localparam logic [31:0] SEED = 32'hbc5195b2;
   localparam int SAMPLE_DELAY  = 40;  // 10 ns ahead of the rising edge.
   localparam int LOAD_WORDS    = 64;
   localparam int RELOAD_WORDS  = 16;
   // worst case cycles of each test.
   localparam int RESET_CYC     = 10;
   localparam int LOAD_CYC      = 260;
   localparam int BRANCH_CYC    = 3;
   localparam int STALL_CYC     = 11;
   localparam int RELOAD_CYC    = 57;
   localparam int TIMEOUT_CYCLES =
      2 * (RESET_CYC + LOAD_CYC + BRANCH_CYC + STALL_CYC + RELOAD_CYC);

   logic               clock;
   logic               soft_reset;
   logic               load_start;
   logic               load_valid;
   if_pkg::instr_t     load_word;
   logic               load_done;
   logic               enable;
   logic               branch;
   if_pkg::addr_t      branch_addr;
   if_pkg::fetch_out_t fetch;
   logic               loading;

   if_pkg::instr_t model [if_pkg::MEM_DEPTH];  // words loaded so far.
   string test_name;
   int    check_count;
   int    error_count;
   int    tests_run;
   int    tests_passed;
   int    handover_pc;      // pc seen at the first sample of the next test.
   int    cycle_count = 0;

   tb_clock u_clock (
      .o_clock      (clock),
      .o_soft_reset (soft_reset)
   );

   fetch_top dut (
      .i_clock       (clock),
      .i_soft_reset  (soft_reset),
      .i_load_start  (load_start),
      .i_load_valid  (load_valid),
      .i_load_word   (load_word),
      .i_load_done   (load_done),
      .i_enable      (enable),
      .i_branch      (branch),
      .i_branch_addr (branch_addr),
      .o_fetch       (fetch),
      .o_loading     (loading)
   );

   always @(posedge clock) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic if_pkg::addr_t to_addr(input int value);
      return value[if_pkg::ADDR_BITS-1:0];
   endfunction

   function automatic if_pkg::instr_t model_word(input int index);
      return model[to_addr(index)];
   endfunction

   task automatic check_instr(input string what, input if_pkg::instr_t exp,
                              input if_pkg::instr_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_addr(input string what, input if_pkg::addr_t exp,
                             input if_pkg::addr_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("[FAIL] %s %s expected %b actual %b", test_name, what, exp, act);
      end
   endtask

   // pc_next always runs one ahead of the shown pc.
   task automatic check_fetch(input if_pkg::instr_t exp_instr, input int exp_pc);
      check_instr("instr", exp_instr, fetch.instr);
      check_addr("pc", to_addr(exp_pc), fetch.pc);
      check_addr("pc_next", to_addr(exp_pc + 1), fetch.pc_next);
   endtask

   task automatic to_fall();
      @(negedge clock);
   endtask

   task automatic to_sample();
      #SAMPLE_DELAY;
   endtask

   task automatic idle_cycle();
      to_fall();
      to_sample();
   endtask

   task automatic check_load_held(input int hold_pc, input if_pkg::instr_t hold_ir,
                                  input logic check_ir);
      check_bit("loading", 1'b1, loading);
      check_addr("pc held", to_addr(hold_pc), fetch.pc);
      if (check_ir) begin
         check_instr("instr held", hold_ir, fetch.instr);
      end
   endtask

   // start, count words with random gaps, done. every word differs from the old one.
   task automatic load_program(input int count, input int max_gap, input logic fetch_on,
                               input logic check_ir, input int hold_pc);
      if_pkg::instr_t hold_ir;
      if_pkg::instr_t word;
      int             gap;
      hold_ir = model_word(hold_pc);
      to_fall();
      load_start = 1'b1;
      to_sample();
      check_bit("loading before start", 1'b0, loading);
      for (int i = 0; i < count; i++) begin
         gap  = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
         word = $urandom;
         if (word == model_word(i)) begin
            word = ~word;
         end
         for (int g = 0; g <= gap; g++) begin
            to_fall();
            load_start = 1'b0;
            enable     = fetch_on;  // loading must still hold the pc.
            load_valid = (g == gap);
            load_word  = word;
            to_sample();
            check_load_held(hold_pc, hold_ir, check_ir);
         end
         model[to_addr(i)] = word;
      end
      to_fall();
      load_valid = 1'b0;
      load_done  = 1'b1;
      enable     = 1'b0;
      to_sample();
      check_load_held(hold_pc, hold_ir, check_ir);
      to_fall();
      load_done = 1'b0;
      to_sample();
      check_bit("loading after done", 1'b0, loading);
      check_addr("pc after load", to_addr(hold_pc), fetch.pc);
   endtask

   task automatic report_test(input int errors_before);
      tests_run++;
      if (error_count == errors_before) begin
         tests_passed++;
         $display("%s: pass", test_name);
      end else begin
         $display("%s: %0d mismatches", test_name, error_count - errors_before);
      end
   endtask

   task automatic test_reset();
      int errors_before;
      test_name     = "reset";
      errors_before = error_count;
      @(posedge soft_reset);
      to_sample();
      check_fetch(if_pkg::IR_RESET, int'(if_pkg::PC_RESET));
      check_bit("loading", 1'b0, loading);
      report_test(errors_before);
   endtask

   task automatic test_load_fetch();
      int errors_before;
      test_name     = "load_fetch";
      errors_before = error_count;
      load_program(LOAD_WORDS, 2, 1'b0, 1'b0, 0);
      to_fall();
      enable = 1'b1;
      to_sample();
      check_addr("pc before fetch", to_addr(0), fetch.pc);
      for (int k = 1; k <= LOAD_WORDS; k++) begin
         idle_cycle();
         check_fetch(model_word(k - 1), k);  // word of the previous pc.
      end
      handover_pc = LOAD_WORDS + 1;
      report_test(errors_before);
   endtask

   task automatic test_branch();
      int errors_before;
      int target;
      test_name     = "branch";
      errors_before = error_count;
      target        = int'($urandom % 48);  // room left for the stall test.
      to_fall();
      branch      = 1'b1;
      branch_addr = to_addr(target);
      to_sample();
      check_addr("pc before branch", to_addr(handover_pc), fetch.pc);
      to_fall();
      branch = 1'b0;
      to_sample();
      check_fetch(if_pkg::NOP_INSTR, target);
      idle_cycle();
      check_fetch(model_word(target), target + 1);
      handover_pc = target + 2;
      report_test(errors_before);
   endtask

   task automatic test_stall();
      int errors_before;
      int q;
      test_name     = "stall";
      errors_before = error_count;
      q             = handover_pc;
      to_fall();
      enable = 1'b0;
      to_sample();
      check_fetch(model_word(q - 1), q);
      repeat (5) begin
         idle_cycle();
         check_fetch(model_word(q), q);  // memory keeps reading the held pc.
      end
      to_fall();
      enable = 1'b1;
      to_sample();
      check_fetch(model_word(q), q);
      for (int k = 1; k <= 4; k++) begin
         idle_cycle();
         check_fetch(model_word(q + k - 1), q + k);
      end
      handover_pc = q + 5;
      report_test(errors_before);
   endtask

   task automatic test_reload();
      int errors_before;
      int hold_pc;
      test_name     = "reload";
      errors_before = error_count;
      to_fall();
      enable = 1'b0;
      to_sample();
      hold_pc = handover_pc;
      check_addr("pc before reload", to_addr(hold_pc), fetch.pc);
      load_program(RELOAD_WORDS, 0, 1'b1, 1'b1, hold_pc);
      // a stray valid while idle would land on the first old word.
      to_fall();
      load_valid = 1'b1;
      load_word  = ~model_word(RELOAD_WORDS);
      to_sample();
      check_bit("loading on stray strobe", 1'b0, loading);
      check_addr("pc on stray strobe", to_addr(hold_pc), fetch.pc);
      to_fall();
      load_valid = 1'b0;
      to_sample();
      check_bit("loading after stray strobe", 1'b0, loading);
      to_fall();
      enable      = 1'b1;
      branch      = 1'b1;
      branch_addr = to_addr(0);
      to_sample();
      to_fall();
      branch = 1'b0;
      to_sample();
      check_fetch(if_pkg::NOP_INSTR, 0);
      for (int k = 0; k < 2 * RELOAD_WORDS; k++) begin
         idle_cycle();
         check_fetch(model_word(k), k + 1);
      end
      to_fall();
      enable = 1'b0;
      to_sample();
      report_test(errors_before);
   endtask

   initial begin
      void'($urandom(SEED));
      load_start   = 1'b0;
      load_valid   = 1'b0;
      load_word    = '0;
      load_done    = 1'b0;
      enable       = 1'b0;
      branch       = 1'b0;
      branch_addr  = '0;
      check_count  = 0;
      error_count  = 0;
      tests_run    = 0;
      tests_passed = 0;
      handover_pc  = 0;
      test_reset();
      test_load_fetch();
      test_branch();
      test_stall();
      test_reload();
      $display("tests %0d, passed %0d, checks %0d, errors %0d",
               tests_run, tests_passed, check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
common/if_pkg.sv
rtl/prog_loader.sv
if_stage/prog_mem.sv
if_stage/pc_unit.sv
if_stage/if_stage.sv
rtl/fetch_top.sv
tests/tb_clock.sv
tests/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
# build the fetch testbench with verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=tb_fetch_sim

verilator --binary --timing --assert -f tb.f --top-module tb_fetch \
   -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
